/* files.f */
logic/spriteGeomPkg.sv
logic/spriteMotionPkg.sv
logic/axisStepIf.sv
logic/horizontalMover.sv
logic/jumpMover.sv
logic/squareBoxGen.sv
logic/squarePosGen.sv
dv/tbClockGen.sv
dv/squarePosTb.sv

/* dv/squarePosTb.sv */
//--------------------------------------------------------------------
// square position generator testbench
// directed tests over the req/ack handshake, a frame model that
// predicts every box position, handshake timing and a cycle limit
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module squarePosTb;
	import spriteGeomPkg::*;
	import spriteMotionPkg::*;

	localparam int timeoutCycles = 60 * 8 + 5;	// frames x worst case + reset

	wire       iClk;
	wire       arstN;
	logic      frameReq, frameAck;
	frameOpT   frameOp;
	sizeT      hDisplay, vDisplay, sizeX, sizeY;
	coordT     startX, startY, basicGainX, basicGainY;
	coordT     leftX, rightX, topY, bottomY;
	logic      leftEn, rightEn, dashEn, upEn, downEn, jumpEn;
	velT       dashGainX, dashPeakX, jumpGainY, jumpMaxY;

	integer    seed = 32'he0f6_68c3;
	integer    errCount = 0;
	integer    cycleCount = 0;
	integer    ackCycles, dropCycles;	// last handshake timing
	// frame model
	integer    mX, mY, mDash, mVel;
	jumpStateT mJump;

	tbClockGen clkGen (.iClk(iClk), .arstN(arstN));

	squarePosGen dut
	(
		.iClk(iClk), .arstN(arstN),
		.frameReq(frameReq), .frameOp(frameOp), .frameAck(frameAck),
		.hDisplay(hDisplay), .vDisplay(vDisplay),
		.startX(startX), .startY(startY), .sizeX(sizeX), .sizeY(sizeY),
		.leftEn(leftEn), .rightEn(rightEn), .dashEn(dashEn),
		.basicGainX(basicGainX), .dashGainX(dashGainX), .dashPeakX(dashPeakX),
		.upEn(upEn), .downEn(downEn), .jumpEn(jumpEn),
		.basicGainY(basicGainY), .jumpGainY(jumpGainY), .jumpMaxY(jumpMaxY),
		.leftX(leftX), .rightX(rightX), .topY(topY), .bottomY(bottomY)
	);

	//------------------------------------------------------------------
	// reporting
	//------------------------------------------------------------------
	task automatic abortRun();
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkVal(input string name, input integer expVal, input integer actVal);
		if (expVal !== actVal)
		begin
			errCount++;
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expVal, actVal);
			abortRun();
		end
	endtask

	always @(posedge iClk)
	begin
		cycleCount++;
		if (cycleCount > timeoutCycles)
		begin
			$display("timeout: the run went past %0d clock cycles", timeoutCycles);
			abortRun();
		end
	end

	//------------------------------------------------------------------
	// frame model
	//------------------------------------------------------------------
	function automatic integer clampTo(input integer v, input integer hi);
		if (v < 0)
			return 0;
		if (v > hi)
			return hi;
		return v;
	endfunction

	task automatic predictFrame(input frameOpT op);
		integer maxX, maxY, spd, dx, dy, cx, cy, nx, ny;
		logic   single, hitX, hitY, launch;
		maxX = integer'(hDisplay) - integer'(sizeX);
		maxY = integer'(vDisplay) - integer'(sizeY);
		if (op == opPlace)
		begin
			mX    = clampTo(startX, maxX);	// restart both movers
			mY    = clampTo(startY, maxY);
			mDash = 0;
			mVel  = 0;
			mJump = jumpIdle;
		end
		else
		begin
			// x: one direction only, dash or basic speed
			single = leftEn ^ rightEn;
			if (dashEn)
				spd = (mDash == 0) ? integer'(dashGainX) : mDash;
			else
				spd = basicGainX;
			dx = !single ? 0 : (leftEn ? -spd : spd);
			cx = mX + dx;
			nx = clampTo(cx, maxX);
			hitX = (nx != cx);
			if (!dashEn || !single || hitX)
				mDash = 0;
			else
				mDash = (spd + 1 > integer'(dashPeakX)) ? integer'(dashPeakX) : spd + 1;
			// y: basic motion or jump arc
			launch = jumpEn && (mY == 0 || mY == maxY);
			case (mJump)
				jumpRise: dy = -mVel;
				jumpFall: dy = mVel;
				default:
				begin
					if (launch)
						dy = -integer'(jumpGainY);
					else if (downEn && !upEn)
						dy = basicGainY;
					else if (upEn && !downEn)
						dy = -basicGainY;
					else
						dy = 0;
				end
			endcase
			cy = mY + dy;
			ny = clampTo(cy, maxY);
			hitY = (ny != cy);
			case (mJump)
				jumpIdle:
					if (launch && (hitY || jumpGainY <= 1))
					begin
						mJump = jumpFall;
						mVel  = 1;
					end
					else if (launch)
					begin
						mJump = jumpRise;
						mVel  = integer'(jumpGainY) - 1;
					end
				jumpRise:
					if (hitY || mVel <= 1)
					begin
						mJump = jumpFall;	// apex or ceiling
						mVel  = 1;
					end
					else
						mVel--;
				default:
					if (hitY)
					begin
						mJump = jumpIdle;	// landed
						mVel  = 0;
					end
					else
						mVel = (mVel + 1 > integer'(jumpMaxY)) ? integer'(jumpMaxY) : mVel + 1;
			endcase
			mX = nx;
			mY = ny;
		end
	endtask

	//------------------------------------------------------------------
	// handshake and box checks
	//------------------------------------------------------------------
	task automatic expectBox(input integer l, input integer t);
		checkVal("leftX", l, leftX);
		checkVal("topY", t, topY);
		checkVal("rightX", l + integer'(sizeX), rightX);
		checkVal("bottomY", t + integer'(sizeY), bottomY);
	endtask

	// full four-phase cycle, called on a falling edge
	task automatic doFrame(input frameOpT op);
		integer waitCnt;
		predictFrame(op);
		frameOp  = op;
		frameReq = 1'b1;
		waitCnt  = 0;
		while (frameAck !== 1'b1)
		begin
			@(negedge iClk);
			waitCnt++;
			if (waitCnt > 8)
			begin
				$display("handshake stalled: frameAck did not rise within 8 cycles");
				abortRun();
			end
		end
		ackCycles = waitCnt;
		expectBox(mX, mY);	// outputs settled before ack
		frameReq = 1'b0;
		waitCnt  = 0;
		while (frameAck !== 1'b0)
		begin
			@(negedge iClk);
			waitCnt++;
			if (waitCnt > 8)
			begin
				$display("handshake stalled: frameAck did not fall within 8 cycles");
				abortRun();
			end
		end
		dropCycles = waitCnt;
	endtask

	task automatic clearControls();
		leftEn  = 1'b0;
		rightEn = 1'b0;
		dashEn  = 1'b0;
		upEn    = 1'b0;
		downEn  = 1'b0;
		jumpEn  = 1'b0;
	endtask

	//------------------------------------------------------------------
	// directed tests, screen 64 x 48, box 8 x 8 -> bounds 56 / 40
	//------------------------------------------------------------------
	task automatic testResetPlace();
		checkVal("frameAck", 0, frameAck);
		expectBox(0, 0);
		startX = -20;	// off screen left / below
		startY = 100;
		doFrame(opPlace);
		expectBox(0, 40);
		checkVal("ackRiseCycles", 3, ackCycles);	// sample edge + 2
		checkVal("ackFallCycles", 1, dropCycles);
		startX = 100;
		startY = -5;
		doFrame(opPlace);
		expectBox(56, 0);
	endtask

	task automatic testBasicMoves();
		basicGainX = 1 + ({$random(seed)} % 4);
		basicGainY = 1 + ({$random(seed)} % 4);
		clearControls();
		startX = 20;
		startY = 20;
		doFrame(opPlace);
		rightEn = 1'b1;
		repeat (2) doFrame(opStep);
		checkVal("leftX", 20 + 2 * basicGainX, leftX);
		rightEn = 1'b0;
		leftEn  = 1'b1;
		repeat (2) doFrame(opStep);
		checkVal("leftX", 20, leftX);
		rightEn = 1'b1;	// both held, no motion
		doFrame(opStep);
		checkVal("leftX", 20, leftX);
		clearControls();
		downEn = 1'b1;
		repeat (2) doFrame(opStep);
		checkVal("topY", 20 + 2 * basicGainY, topY);
		downEn = 1'b0;
		upEn   = 1'b1;
		doFrame(opStep);
		checkVal("topY", 20 + basicGainY, topY);
		downEn = 1'b1;
		doFrame(opStep);
		checkVal("topY", 20 + basicGainY, topY);
		// walls
		clearControls();
		startX = 2;
		doFrame(opPlace);
		leftEn = 1'b1;
		repeat (2) doFrame(opStep);
		checkVal("leftX", 0, leftX);
		clearControls();
		startX = 54;
		doFrame(opPlace);
		rightEn = 1'b1;
		repeat (2) doFrame(opStep);
		checkVal("leftX", 56, leftX);
		clearControls();
		startX = 20;
		startY = 2;
		doFrame(opPlace);
		upEn = 1'b1;
		repeat (2) doFrame(opStep);
		checkVal("topY", 0, topY);
	endtask

	task automatic testDash();
		integer pos, i, prevX, n;
		clearControls();
		startX = 4;
		startY = 40;
		doFrame(opPlace);
		rightEn = 1'b1;
		dashEn  = 1'b1;
		pos     = 4;
		for (i = 0; i < 5; i++)
		begin
			// gain, gain + 1, ... up to the peak
			if (integer'(dashGainX) + i < integer'(dashPeakX))
				pos = pos + integer'(dashGainX) + i;
			else
				pos = pos + integer'(dashPeakX);
			doFrame(opStep);
			checkVal("dash leftX", pos, leftX);
		end
		dashEn = 1'b0;	// release drops the dash
		doFrame(opStep);
		dashEn = 1'b1;
		prevX  = leftX;
		doFrame(opStep);
		checkVal("dash restart dx", dashGainX, leftX - prevX);
		n = 0;
		while (leftX != 56 && n < 10)
		begin
			doFrame(opStep);
			n++;
		end
		doFrame(opStep);	// one more push, clamped on the wall
		checkVal("wall leftX", 56, leftX);
		rightEn = 1'b0;
		leftEn  = 1'b1;
		doFrame(opStep);
		checkVal("after wall leftX", 56 - integer'(dashGainX), leftX);
	endtask

	task automatic testJump();
		integer prevY, v, expY, n;
		clearControls();
		startX = 20;
		startY = 40;	// on the ground
		doFrame(opPlace);
		jumpEn = 1'b1;	// held through the arc
		for (v = jumpGainY; v >= 1; v--)
		begin
			prevY = topY;
			doFrame(opStep);
			checkVal("rise dy", -v, topY - prevY);
		end
		v = 1;
		n = 0;
		do
		begin
			prevY = topY;
			doFrame(opStep);
			expY = prevY + ((v < integer'(jumpMaxY)) ? v : integer'(jumpMaxY));
			if (expY > 40)
				expY = 40;	// landing clamp
			checkVal("fall topY", expY, topY);
			v++;
			n++;
		end while (topY != 40 && n < 10);
		checkVal("landed topY", 40, topY);
		jumpEn = 1'b0;
		upEn   = 1'b1;	// idle again -> basic up
		doFrame(opStep);
		checkVal("topY", 40 - basicGainY, topY);
	endtask

	task automatic testPlaceMidJump();
		integer prevY;
		clearControls();
		startX = 10;
		startY = 40;
		doFrame(opPlace);
		rightEn = 1'b1;
		dashEn  = 1'b1;
		jumpEn  = 1'b1;
		doFrame(opStep);	// launch
		prevY = topY;
		doFrame(opStep);
		checkVal("airborne dy", -(integer'(jumpGainY) - 1), topY - prevY);
		jumpEn = 1'b0;
		doFrame(opPlace);	// mid arc
		downEn = 1'b1;
		doFrame(opStep);
		expectBox(10 + integer'(dashGainX), 40);
	endtask

	//------------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------------
	initial
	begin
		frameReq   = 1'b0;
		frameOp    = opStep;
		hDisplay   = 11'd64;
		vDisplay   = 11'd48;
		sizeX      = 11'd8;
		sizeY      = 11'd8;
		startX     = '0;
		startY     = '0;
		basicGainX = 12'sd1;
		basicGainY = 12'sd1;
		dashGainX  = 5'd2;
		dashPeakX  = 5'd5;
		jumpGainY  = 5'd4;
		jumpMaxY   = 5'd3;
		clearControls();
		mX    = 0;
		mY    = 0;
		mDash = 0;
		mVel  = 0;
		mJump = jumpIdle;
		wait (arstN === 1'b1);
		@(negedge iClk);
		testResetPlace();
		testBasicMoves();
		testDash();
		testJump();
		testPlaceMidJump();
		if (errCount == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
			abortRun();
	end

endmodule

`default_nettype wire

/* dv/tbClockGen.sv */
//--------------------------------------------------------------------
// testbench clock and reset
// 10 ns clock, active low reset held for five cycles and
// released on a falling edge
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tbClockGen
(
	output logic iClk,
	output logic arstN
);

	initial
	begin
		iClk = 1'b0;
		forever #5 iClk = ~iClk;	// 100 MHz
	end

	initial
	begin
		arstN = 1'b0;
		repeat (5) @(posedge iClk);
		@(negedge iClk);	// away from the sampling edge
		arstN = 1'b1;
	end

endmodule

`default_nettype wire

/* logic/squarePosGen.sv */
//--------------------------------------------------------------------
// square position generator, top level
// one square sprite stepped per frame over a req/ack handshake,
// x and y movers feeding the clamping box generator
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module squarePosGen
(
	input  wire                     iClk,
	input  wire                     arstN,
	// handshake
	input  wire                     frameReq,
	input  spriteGeomPkg::frameOpT  frameOp,
	output logic                    frameAck,
	// screen and box
	input  spriteGeomPkg::sizeT     hDisplay,
	input  spriteGeomPkg::sizeT     vDisplay,
	input  spriteGeomPkg::coordT    startX,
	input  spriteGeomPkg::coordT    startY,
	input  spriteGeomPkg::sizeT     sizeX,
	input  spriteGeomPkg::sizeT     sizeY,
	// horizontal controls
	input  wire                     leftEn,
	input  wire                     rightEn,
	input  wire                     dashEn,
	input  spriteGeomPkg::coordT    basicGainX,
	input  spriteMotionPkg::velT    dashGainX,
	input  spriteMotionPkg::velT    dashPeakX,
	// vertical controls
	input  wire                     upEn,
	input  wire                     downEn,
	input  wire                     jumpEn,
	input  spriteGeomPkg::coordT    basicGainY,
	input  spriteMotionPkg::velT    jumpGainY,
	input  spriteMotionPkg::velT    jumpMaxY,
	// box corners
	output spriteGeomPkg::coordT    leftX,
	output spriteGeomPkg::coordT    rightX,
	output spriteGeomPkg::coordT    topY,
	output spriteGeomPkg::coordT    bottomY
);

	axisStepIf xAxis ();	// horizontal mover <-> box
	axisStepIf yAxis ();	// jump mover <-> box

	horizontalMover uHorz
	(
		.iClk(iClk), .arstN(arstN),
		.leftEn(leftEn), .rightEn(rightEn), .dashEn(dashEn),
		.basicGainX(basicGainX), .dashGainX(dashGainX), .dashPeakX(dashPeakX),
		.axis(xAxis)
	);

	jumpMover uJump
	(
		.iClk(iClk), .arstN(arstN),
		.upEn(upEn), .downEn(downEn), .jumpEn(jumpEn),
		.basicGainY(basicGainY), .jumpGainY(jumpGainY), .jumpMaxY(jumpMaxY),
		.axis(yAxis)
	);

	squareBoxGen uBox
	(
		.iClk(iClk), .arstN(arstN),
		.frameReq(frameReq), .frameOp(frameOp), .frameAck(frameAck),
		.hDisplay(hDisplay), .vDisplay(vDisplay),
		.startX(startX), .startY(startY), .sizeX(sizeX), .sizeY(sizeY),
		.leftX(leftX), .rightX(rightX), .topY(topY), .bottomY(bottomY),
		.xAxis(xAxis), .yAxis(yAxis)
	);

endmodule

`default_nettype wire

/* logic/squareBoxGen.sv */
//--------------------------------------------------------------------
// square box generator
// req/ack handshake control, left/top position registers, clamp
// of the moved or placed box onto the screen, and the corners
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module squareBoxGen
(
	input  wire                     iClk,
	input  wire                     arstN,
	input  wire                     frameReq,
	input  spriteGeomPkg::frameOpT  frameOp,
	output logic                    frameAck,
	input  spriteGeomPkg::sizeT     hDisplay,
	input  spriteGeomPkg::sizeT     vDisplay,
	input  spriteGeomPkg::coordT    startX,
	input  spriteGeomPkg::coordT    startY,
	input  spriteGeomPkg::sizeT     sizeX,
	input  spriteGeomPkg::sizeT     sizeY,
	output spriteGeomPkg::coordT    leftX,
	output spriteGeomPkg::coordT    rightX,
	output spriteGeomPkg::coordT    topY,
	output spriteGeomPkg::coordT    bottomY,
	axisStepIf.box                  xAxis,
	axisStepIf.box                  yAxis
);
	import spriteGeomPkg::*;
	import spriteMotionPkg::*;

	hsStateT                    hsState;
	coordT                      posX, posY;		// left / top
	logic signed [coordWidth:0] maxX, maxY;		// upper clamp bound
	logic signed [coordWidth:0] candX, candY;	// one bit wider, no wrap
	coordT                      clampX, clampY;
	logic                       update, doStep;

	// clamp to 0 .. hiBound
	function automatic coordT clampAxis(input logic signed [coordWidth:0] cand,
		input logic signed [coordWidth:0] hiBound);
		coordT res;
		if (cand < 0)
			res = '0;
		else if (cand > hiBound)
			res = hiBound[coordWidth-1:0];
		else
			res = cand[coordWidth-1:0];
		return res;
	endfunction

	//------------------------------------------------------------------
	// next position
	//------------------------------------------------------------------
	assign update = (hsState == hsUpdate);
	assign doStep = update && (frameOp == opStep);

	assign maxX = $signed({1'b0, hDisplay}) - $signed({1'b0, sizeX});
	assign maxY = $signed({1'b0, vDisplay}) - $signed({1'b0, sizeY});

	always_comb
	begin
		if (frameOp == opPlace)
		begin
			candX = startX;	// may be off screen
			candY = startY;
		end
		else
		begin
			candX = posX + xAxis.delta;
			candY = posY + yAxis.delta;
		end
	end

	assign clampX = clampAxis(candX, maxX);
	assign clampY = clampAxis(candY, maxY);

	// strobes and edge flags back to the movers
	assign xAxis.step     = doStep;
	assign yAxis.step     = doStep;
	assign xAxis.restart  = update && (frameOp == opPlace);
	assign yAxis.restart  = update && (frameOp == opPlace);
	assign xAxis.hitLimit = doStep && (clampX != candX);
	assign yAxis.hitLimit = doStep && (clampY != candY);
	assign xAxis.atLimit  = (posX == 0) || (posX == maxX);
	assign yAxis.atLimit  = (posY == 0) || (posY == maxY);

	//------------------------------------------------------------------
	// handshake FSM and position registers
	//------------------------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hsState  <= hsIdle;
			frameAck <= 1'b0;
			posX     <= '0;
			posY     <= '0;
		end
		else
		begin
			case (hsState)
				hsIdle:
					if (frameReq)
						hsState <= hsUpdate;
				hsUpdate:
				begin
					posX    <= clampX;	// movers update on this edge too
					posY    <= clampY;
					hsState <= hsAck;
				end
				hsAck:
				begin
					frameAck <= frameReq;	// high one cycle after entry
					if (!frameReq)
						hsState <= hsIdle;
				end
				default: hsState <= hsIdle;
			endcase
		end
	end

	//------------------------------------------------------------------
	// corners
	//------------------------------------------------------------------
	assign leftX   = posX;
	assign topY    = posY;
	assign rightX  = posX + coordT'(sizeX);
	assign bottomY = posY + coordT'(sizeY);

endmodule

`default_nettype wire

/* logic/jumpMover.sv */
//--------------------------------------------------------------------
// jump mover
// signed y delta from the up/down enables, plus a jump arc
// launched from a clamp edge: rise with decaying speed, apex,
// fall with growing speed until the box lands on the edge
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module jumpMover
(
	input  wire                    iClk,
	input  wire                    arstN,
	input  wire                    upEn,
	input  wire                    downEn,
	input  wire                    jumpEn,
	input  spriteGeomPkg::coordT   basicGainY,
	input  spriteMotionPkg::velT   jumpGainY,
	input  spriteMotionPkg::velT   jumpMaxY,
	axisStepIf.mover               axis
);
	import spriteGeomPkg::*;
	import spriteMotionPkg::*;

	jumpStateT          jumpState;
	velT                vel;		// speed of the running arc
	logic [velWidth:0]  velInc;	// fall speed + 1, no wrap
	logic               launch;	// jump starts this frame
	coordT              basicDelta;

	assign launch = jumpEn && axis.atLimit;	// only from an edge
	assign velInc = vel + 1'b1;

	// down is positive on screen
	always_comb
	begin
		if (downEn && !upEn)
			basicDelta = basicGainY;
		else if (upEn && !downEn)
			basicDelta = -basicGainY;
		else
			basicDelta = '0;
	end

	//------------------------------------------------------------------
	// delta per state
	//------------------------------------------------------------------
	always_comb
	begin
		case (jumpState)
			jumpRise: axis.delta = -coordT'(vel);
			jumpFall: axis.delta = coordT'(vel);
			default:
			begin
				if (launch)
					axis.delta = -coordT'(jumpGainY);	// first rise frame
				else
					axis.delta = basicDelta;
			end
		endcase
	end

	//------------------------------------------------------------------
	// arc state machine
	//------------------------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			jumpState <= jumpIdle;
			vel       <= '0;
		end
		else if (axis.restart)
		begin
			jumpState <= jumpIdle;	// placement cancels the arc
			vel       <= '0;
		end
		else if (axis.step)
		begin
			case (jumpState)
				jumpIdle:
				begin
					if (launch && (axis.hitLimit || jumpGainY <= velT'(1)))
					begin
						jumpState <= jumpFall;	// apex right away
						vel       <= velT'(1);
					end
					else if (launch)
					begin
						jumpState <= jumpRise;
						vel       <= jumpGainY - 1'b1;
					end
				end
				jumpRise:
				begin
					if (axis.hitLimit || vel <= velT'(1))
					begin
						jumpState <= jumpFall;	// apex or ceiling
						vel       <= velT'(1);
					end
					else
						vel <= vel - 1'b1;
				end
				jumpFall:
				begin
					if (axis.hitLimit)
					begin
						jumpState <= jumpIdle;	// landed
						vel       <= '0;
					end
					else if (velInc >= {1'b0, jumpMaxY})
						vel <= jumpMaxY;	// terminal speed
					else
						vel <= velInc[velWidth-1:0];
				end
				default:
				begin
					jumpState <= jumpIdle;
					vel       <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/horizontalMover.sv */
//--------------------------------------------------------------------
// horizontal mover
// signed x delta from the left/right enables, basic speed or a
// dash that speeds up by one per frame up to a peak
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module horizontalMover
(
	input  wire                    iClk,
	input  wire                    arstN,
	input  wire                    leftEn,
	input  wire                    rightEn,
	input  wire                    dashEn,
	input  spriteGeomPkg::coordT   basicGainX,
	input  spriteMotionPkg::velT   dashGainX,
	input  spriteMotionPkg::velT   dashPeakX,
	axisStepIf.mover               axis
);
	import spriteGeomPkg::*;
	import spriteMotionPkg::*;

	//------------------------------------------------------------------
	// speed select
	//------------------------------------------------------------------
	velT                dashSpeed;	// 0 = dash not running yet
	velT                dashUsed;	// dash speed for this frame
	logic [velWidth:0]  dashNext;	// one extra bit, no wrap
	coordT              speed;
	logic               singleDir;

	assign singleDir = leftEn ^ rightEn;	// both or none -> stand still

	// first dash frame starts at the gain
	assign dashUsed = (dashSpeed == '0) ? dashGainX : dashSpeed;
	assign dashNext = dashUsed + 1'b1;

	always_comb
	begin
		if (dashEn)
			speed = coordT'(dashUsed);	// zero extended
		else
			speed = basicGainX;
	end

	// sign from direction, left is negative
	always_comb
	begin
		if (!singleDir)
			axis.delta = '0;
		else if (leftEn)
			axis.delta = -speed;
		else
			axis.delta = speed;
	end

	//------------------------------------------------------------------
	// dash register
	//------------------------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
			dashSpeed <= '0;
		else if (axis.restart)
			dashSpeed <= '0;	// placement drops the dash
		else if (axis.step)
		begin
			if (!dashEn || !singleDir || axis.hitLimit)
				dashSpeed <= '0;	// released, turned or hit a wall
			else if (dashNext >= {1'b0, dashPeakX})
				dashSpeed <= dashPeakX;	// saturate
			else
				dashSpeed <= dashNext[velWidth-1:0];
		end
	end

endmodule

`default_nettype wire

/* logic/axisStepIf.sv */
//--------------------------------------------------------------------
// axis step link
// one per axis, carries the frame strobes and edge flags from the
// box generator and the signed delta back from the mover
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface axisStepIf;
	import spriteGeomPkg::*;

	logic  step;		// one cycle, advance this frame
	logic  restart;		// one cycle, placement
	coordT delta;		// comb from mover state and inputs
	logic  atLimit;		// position sits on a clamp edge
	logic  hitLimit;	// this step was clamped

	// mover side
	modport mover
	(
		input  step,
		input  restart,
		input  atLimit,
		input  hitLimit,
		output delta
	);

	// box generator side
	modport box
	(
		output step,
		output restart,
		output atLimit,
		output hitLimit,
		input  delta
	);

endinterface

`default_nettype wire

/* logic/spriteMotionPkg.sv */
//--------------------------------------------------------------------
// sprite motion definitions
// speed widths for dash and jump, the jump arc states and the
// states of the req/ack handshake controller
//--------------------------------------------------------------------
`default_nettype none

package spriteMotionPkg;

	//------------------------------------------------------------------
	// speeds
	//------------------------------------------------------------------
	localparam int velWidth = 5;	// dash and jump speeds, unsigned

	typedef logic [velWidth-1:0] velT;

	//------------------------------------------------------------------
	// jump arc
	//------------------------------------------------------------------
	typedef enum logic [1:0]
	{
		jumpIdle = 2'd0,	// on ground, basic up/down motion
		jumpRise = 2'd1,	// moving up, speed decays
		jumpFall = 2'd2		// moving down, speed grows
	} jumpStateT;

	//------------------------------------------------------------------
	// handshake controller
	//------------------------------------------------------------------
	// idle -> update (one cycle) -> ack until req drops
	typedef enum logic [1:0]
	{
		hsIdle   = 2'd0,	// wait for frameReq
		hsUpdate = 2'd1,	// step/restart strobe, positions written
		hsAck    = 2'd2		// frameAck held until req low
	} hsStateT;

endpackage

`default_nettype wire

/* logic/spriteGeomPkg.sv */
//--------------------------------------------------------------------
// sprite geometry definitions
// coordinate and size widths, their types and the frame command
// opcodes shared by the box generator and the top level
//--------------------------------------------------------------------
`default_nettype none

package spriteGeomPkg;

	//------------------------------------------------------------------
	// widths
	//------------------------------------------------------------------
	localparam int coordWidth = 12;	// signed, one bit above sizeWidth
	localparam int sizeWidth  = 11;	// unsigned screen / box size

	//------------------------------------------------------------------
	// types
	//------------------------------------------------------------------
	// positions and deltas, may lie off screen
	typedef logic signed [coordWidth-1:0] coordT;

	// hDisplay, vDisplay, sizeX, sizeY
	typedef logic [sizeWidth-1:0] sizeT;

	// host command, sampled with frameReq
	typedef enum logic
	{
		opStep  = 1'b0,	// advance one frame
		opPlace = 1'b1	// load start position, restart movers
	} frameOpT;

endpackage

`default_nettype wire
